// ==== project.f ====
src/noc_cfg_pkg.sv
src/flit_pkg.sv
src/flit_fifo.sv
src/input_unit.sv
src/output_unit.sv
src/router.sv
test/router_tb.sv

// ==== Makefile ====
# Verilator build and run of the router testbench

TOP = router_tb
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -o $(TOP)_sim

run: build
	./obj_dir/$(TOP)_sim | tee $(LOG)
	grep -qx "test passed" $(LOG)

lint:
	verilator --lint-only -Wall --timing --assert -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

// ==== test/router_tb.sv ====
/*
 * Testbench for the five-port router, route table maps d to port d mod NUM_PORTS
 * Each output has a scoreboard queue filled in the expected delivery order
 * Downstream returns one credit per flit a cycle later unless held
 * Tests assume the arbitration output of test 4 has not been used before
 */
`timescale 1ns/100ps
`default_nettype none

module router_tb
    import noc_cfg_pkg::*, flit_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 200;
    localparam int HOLD_WINDOW    = 12;

    logic                  clk = 1'b0;
    logic                  rst_n;
    route_table_t          route_table;
    link_t [NUM_PORTS-1:0] link_in;
    port_mask_t            credit_out;
    link_t [NUM_PORTS-1:0] link_out;
    port_mask_t            credit_in = '0;

    // Stimulus streams per input and expected flits per output
    flit_t      streams [NUM_PORTS][$];
    flit_t      sb      [NUM_PORTS][$];
    flit_t      exp_head [NUM_PORTS];
    logic       exp_valid [NUM_PORTS];
    int         pending   [NUM_PORTS];
    int         delivered [NUM_PORTS];
    int         sent_cnt  [NUM_PORTS];
    int         ret_cnt   [NUM_PORTS];
    port_mask_t hold = '0;
    port_mask_t out_sends;
    logic       stim_started;
    int         seed = 40;
    int         errors;
    int         test_start_errors;
    int         tests_run;
    int         tests_bad;
    string      test_name;

    router dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .route_table (route_table),
        .link_in     (link_in),
        .credit_out  (credit_out),
        .link_out    (link_out),
        .credit_in   (credit_in)
    );

    always #10 clk = ~clk;

    always_comb begin
        for (int j = 0; j < NUM_PORTS; j++) begin
            out_sends[j] = link_out[j].send;
        end
    end

    // Scoreboard, downstream occupancy and upstream credit bookkeeping
    always @(posedge clk) begin
        for (int j = 0; j < NUM_PORTS; j++) begin
            if (!rst_n) begin
                pending[j]   <= 0;
                delivered[j] <= 0;
                ret_cnt[j]   <= 0;
            end else begin
                pending[j] <= pending[j] + int'(link_out[j].send) - int'(credit_in[j]);
                if (link_out[j].send) begin
                    delivered[j] <= delivered[j] + 1;
                    if (sb[j].size() != 0) begin
                        void'(sb[j].pop_front());
                    end
                end
                if (credit_out[j]) begin
                    ret_cnt[j] <= ret_cnt[j] + 1;
                end
            end
            exp_valid[j] <= (sb[j].size() != 0);
            exp_head[j]  <= (sb[j].size() != 0) ? sb[j][0] : '0;
        end
    end

    // Downstream receiver, one credit back per cycle while not held
    always @(negedge clk) begin
        for (int j = 0; j < NUM_PORTS; j++) begin
            credit_in[j] <= rst_n && !hold[j] && (pending[j] > 0);
        end
    end

    idle_a: assert property (@(posedge clk) disable iff (!rst_n)
        !stim_started |-> (out_sends == '0 && credit_out == '0))
    else begin
        errors++;
        $display("error %s expected send 00000 credit 00000 actual send %b credit %b",
                 test_name, $sampled(out_sends), $sampled(credit_out));
    end

    for (genvar j = 0; j < NUM_PORTS; j++) begin : g_check
        delivery_a: assert property (@(posedge clk) disable iff (!rst_n)
            link_out[j].send |-> (exp_valid[j] && link_out[j].flit == exp_head[j]))
        else begin
            errors++;
            $display("error %s output %0d expected %h (valid %0d) actual %h", test_name, j,
                     $sampled(exp_head[j]), $sampled(exp_valid[j]), $sampled(link_out[j].flit));
        end

        // At most BUFFER_DEPTH flits may sit in the downstream buffer
        downstream_credit_a: assert property (@(posedge clk) disable iff (!rst_n)
            link_out[j].send |-> (pending[j] < BUFFER_DEPTH))
        else begin
            errors++;
            $display("error %s output %0d expected below %0d flits in flight actual %0d",
                     test_name, j, BUFFER_DEPTH, $sampled(pending[j]));
        end

        credit_return_a: assert property (@(posedge clk) disable iff (!rst_n)
            credit_out[j] |-> (sent_cnt[j] > ret_cnt[j]))
        else begin
            errors++;
            $display("error %s input %0d returned a credit for a flit it never received",
                     test_name, j);
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("test failed");
        $finish;
    endtask

    // Queue one packet on an input and its flits at the expected output
    task automatic add_packet(input int src, input int dest, input int len);
        flit_t f;
        for (int k = 0; k < len; k++) begin
            f.data    = flit_data_t'($random(seed));
            f.dest    = dest_t'(dest);
            f.is_tail = (k == len - 1);
            streams[src].push_back(f);
            sb[dest % NUM_PORTS].push_back(f);
        end
    endtask

    // Called at a falling edge, sends only with an upstream credit in hand
    task automatic drive_stream(input int src);
        int waited;
        while (streams[src].size() != 0) begin
            waited = 0;
            while (sent_cnt[src] - ret_cnt[src] >= BUFFER_DEPTH) begin
                @(negedge clk);
                waited++;
                if (waited > TIMEOUT_CYCLES) begin
                    abort_run($sformatf("timeout in %s: input %0d never got a credit back",
                                        test_name, src));
                end
            end
            link_in[src].send = 1'b1;
            link_in[src].flit = streams[src].pop_front();
            sent_cnt[src]++;
            stim_started = 1'b1;
            @(negedge clk);
            link_in[src].send = 1'b0;
        end
    endtask

    task automatic wait_delivered(input int port, input int target);
        int waited;
        waited = 0;
        while (delivered[port] < target) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                abort_run($sformatf("timeout in %s: output %0d never delivered flit %0d",
                                    test_name, port, target));
            end
        end
    endtask

    task automatic wait_drained();
        int waited;
        for (int j = 0; j < NUM_PORTS; j++) begin
            waited = 0;
            while (sb[j].size() != 0) begin
                @(negedge clk);
                waited++;
                if (waited > TIMEOUT_CYCLES) begin
                    abort_run($sformatf("timeout in %s: output %0d never delivered %0d flits",
                                        test_name, j, sb[j].size()));
                end
            end
        end
    endtask

    // Changes at a rising edge so the credit driver never races it
    task automatic set_hold(input int port, input logic value);
        @(posedge clk);
        hold[port] = value;
        @(negedge clk);
    endtask

    task automatic start_test(input string name);
        test_name         = name;
        test_start_errors = errors;
        repeat (4) @(negedge clk);
    endtask

    task automatic end_test();
        wait_drained();
        for (int i = 0; i < NUM_PORTS; i++) begin
            credits_back_a: assert (ret_cnt[i] == sent_cnt[i]) else begin
                errors++;
                $display("error %s input %0d expected %0d credits actual %0d",
                         test_name, i, sent_cnt[i], ret_cnt[i]);
            end
        end
        tests_run++;
        if (errors == test_start_errors) begin
            $display("%s: ok", test_name);
        end else begin
            tests_bad++;
            $display("%s: %0d errors", test_name, errors - test_start_errors);
        end
    endtask

    initial begin
        int base;
        rst_n        = 1'b0;
        link_in      = '0;
        stim_started = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_bad    = 0;
        test_name    = "reset";
        for (int d = 0; d < NUM_ENDPOINTS; d++) begin
            route_table[d] = port_idx_t'(d % NUM_PORTS);
        end
        for (int i = 0; i < NUM_PORTS; i++) begin
            sent_cnt[i] = 0;
        end
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        start_test("idle_after_reset");
        repeat (10) @(negedge clk);
        end_test();

        start_test("single_flit");
        add_packet(2, 3, 1);
        drive_stream(2);
        end_test();

        start_test("four_flit_packet");
        add_packet(3, 6, 4);
        drive_stream(3);
        end_test();

        // Output 4 is still in reset order, input 0 wins first
        start_test("arbitration_order");
        add_packet(0, 4, 2);
        add_packet(1, 4, 2);
        add_packet(0, 4, 2);
        add_packet(1, 4, 2);
        fork
            drive_stream(0);
            drive_stream(1);
        join
        end_test();

        start_test("back_pressure");
        base = delivered[0];
        set_hold(0, 1'b1);
        add_packet(4, 5, 6);
        fork
            drive_stream(4);
            begin
                wait_delivered(0, base + BUFFER_DEPTH);
                repeat (HOLD_WINDOW) @(negedge clk);
                held_count_a: assert (delivered[0] == base + BUFFER_DEPTH) else begin
                    errors++;
                    $display("error %s expected %0d flits while held actual %0d",
                             test_name, BUFFER_DEPTH, delivered[0] - base);
                end
                set_hold(0, 1'b0);
            end
        join
        end_test();

        start_test("parallel_ports");
        add_packet(0, 1, 3);
        add_packet(1, 2, 3);
        add_packet(2, 3, 3);
        add_packet(3, 0, 3);
        fork
            drive_stream(0);
            drive_stream(1);
            drive_stream(2);
            drive_stream(3);
        join
        end_test();

        $display("%0d tests run, %0d with errors, %0d check failures",
                 tests_run, tests_bad, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/router.sv ====
/*
 * Five-port NoC router with credit-based links, single-cycle traversal
 * Upstream senders and downstream receivers start with BUFFER_DEPTH credits
 * Packets are routed by the head flit's destination through route_table
 */
`timescale 1ns/100ps
`default_nettype none

module router
    import noc_cfg_pkg::*, flit_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,

    input  route_table_t          route_table,

    input  link_t [NUM_PORTS-1:0] link_in,
    output port_mask_t            credit_out,

    output link_t [NUM_PORTS-1:0] link_out,
    input  port_mask_t            credit_in
);

    // Indexed [input][output] and [output][input]
    port_mask_t [NUM_PORTS-1:0] req_by_input;
    port_mask_t [NUM_PORTS-1:0] req_by_output;
    port_mask_t [NUM_PORTS-1:0] take_by_output;
    port_mask_t [NUM_PORTS-1:0] take_by_input;
    flit_t      [NUM_PORTS-1:0] head_flits;

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            for (int j = 0; j < NUM_PORTS; j++) begin
                req_by_output[j][i] = req_by_input[i][j];
                take_by_input[i][j] = take_by_output[j][i];
            end
        end
    end

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
        input_unit in_unit (
            .clk         (clk),
            .rst_n       (rst_n),
            .link_in     (link_in[i]),
            .credit      (credit_out[i]),
            .route_table (route_table),
            .take        (take_by_input[i]),
            .request     (req_by_input[i]),
            .head_flit   (head_flits[i])
        );

        output_unit out_unit (
            .clk        (clk),
            .rst_n      (rst_n),
            .request    (req_by_output[i]),
            .head_flits (head_flits),
            .take       (take_by_output[i]),
            .link_out   (link_out[i]),
            .credit     (credit_in[i])
        );
    end

endmodule

`default_nettype wire

// ==== src/output_unit.sv ====
/*
 * One router output port with matrix arbiter, crossbar column and credit counter
 * A grant is held from the head flit until the tail flit has been sent
 * Downstream must return exactly one credit per flit it received
 */
`timescale 1ns/100ps
`default_nettype none

module output_unit
    import noc_cfg_pkg::*, flit_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,

    // From the input units
    input  port_mask_t            request,
    input  flit_t [NUM_PORTS-1:0] head_flits,
    output port_mask_t            take,

    // Downstream link
    output link_t                 link_out,
    input  logic                  credit
);

    // prio[i][j] set means input i wins over input j
    logic [NUM_PORTS-1:0][NUM_PORTS-1:0] prio;

    port_mask_t  grant_free;
    port_mask_t  grant;
    port_mask_t  new_grant;
    port_mask_t  lock_grant;
    logic        locked;
    logic        send;
    flit_t       sel_flit;
    credit_cnt_t credit_cnt;

    // An input wins when no other requester beats it
    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            grant_free[i] = request[i];
            for (int j = 0; j < NUM_PORTS; j++) begin
                if (j != i && request[j] && prio[j][i]) begin
                    grant_free[i] = 1'b0;
                end
            end
        end
    end

    assign grant     = locked ? lock_grant : grant_free;
    assign new_grant = locked ? '0 : grant_free;

    // Crossbar column for this output
    always_comb begin
        sel_flit = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (grant[i]) begin
                sel_flit = flit_t'(sel_flit | head_flits[i]);
            end
        end
    end

    // Locked input may be momentarily empty mid-packet
    assign send = |(grant & request) && (credit_cnt != '0);
    assign take = send ? grant : '0;

    assign link_out.send = send;
    assign link_out.flit = sel_flit;

    // Packet lock is released in the cycle the tail leaves
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            locked     <= 1'b0;
            lock_grant <= '0;
        end else if (send && sel_flit.is_tail) begin
            locked <= 1'b0;
        end else if (|new_grant) begin
            locked     <= 1'b1;
            lock_grant <= new_grant;
        end
    end

    // Newly granted input drops below all the others
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                for (int j = 0; j < NUM_PORTS; j++) begin
                    prio[i][j] <= (i < j);
                end
            end
        end else begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                for (int j = 0; j < NUM_PORTS; j++) begin
                    if (i != j && new_grant[i]) begin
                        prio[i][j] <= 1'b0;
                    end else if (i != j && new_grant[j]) begin
                        prio[i][j] <= 1'b1;
                    end
                end
            end
        end
    end

    // Downstream buffer space
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credit_cnt <= credit_cnt_t'(BUFFER_DEPTH);
        end else begin
            case ({send, credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    grant_onehot_a: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(grant));

    // Over-returned credits or a send at zero credit take the counter out of range
    credit_bound_a: assert property (@(posedge clk) disable iff (!rst_n)
        credit_cnt <= credit_cnt_t'(BUFFER_DEPTH));

endmodule

`default_nettype wire

// ==== src/input_unit.sv ====
/*
 * One router input port with its buffer, packet state and route lookup
 * The route comes from the head flit and stays locked until the tail pops
 * Route table entries must name a valid port below NUM_PORTS
 */
`timescale 1ns/100ps
`default_nettype none

module input_unit
    import noc_cfg_pkg::*, flit_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,

    // Upstream link
    input  link_t        link_in,
    output logic         credit,

    input  route_table_t route_table,

    // Toward the output units
    input  port_mask_t   take,
    output port_mask_t   request,
    output flit_t        head_flit
);

    logic      head_valid;
    logic      pop;
    logic      in_transit;
    port_idx_t locked_route;
    port_idx_t table_route;
    port_idx_t route;

    flit_fifo buffer0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (link_in.send),
        .push_flit  (link_in.flit),
        .pop        (pop),
        .head_flit  (head_flit),
        .head_valid (head_valid)
    );

    // Any output taking our head flit drains one entry
    assign pop    = |take;
    assign credit = pop;

    // Lookup only matters while the head of the buffer is a head flit
    assign table_route = route_table[head_flit.dest];
    assign route       = in_transit ? locked_route : table_route;

    always_comb begin
        request        = '0;
        request[route] = head_valid;
    end

    // A popped head flit locks the route for the body of the packet
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_transit   <= 1'b0;
            locked_route <= '0;
        end else if (pop) begin
            in_transit <= ~head_flit.is_tail;
            if (!in_transit) begin
                locked_route <= table_route;
            end
        end
    end

    // Only one output may take a given flit
    take_onehot_a: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(take));

endmodule

`default_nettype wire

// ==== src/flit_fifo.sv ====
/*
 * First-word-fall-through flit buffer of BUFFER_DEPTH entries
 * Has no full flag and relies on the upstream credit protocol
 * A pushed flit shows at the head one cycle after the push edge
 */
`timescale 1ns/100ps
`default_nettype none

module flit_fifo
    import noc_cfg_pkg::*, flit_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,

    input  logic  push,
    input  flit_t push_flit,

    input  logic  pop,
    output flit_t head_flit,
    output logic  head_valid
);

    flit_t       mem [BUFFER_DEPTH];
    buf_ptr_t    rd_ptr;
    buf_ptr_t    wr_ptr;
    credit_cnt_t count;

    // Flit storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_flit;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head_flit  = mem[rd_ptr];
    assign head_valid = (count != '0);

    // Sender must respect its credits
    push_not_full_a: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> (count != credit_cnt_t'(BUFFER_DEPTH)));

    // Takes from the output side only arrive for a valid head
    pop_not_empty_a: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> (count != '0));

endmodule

`default_nettype wire

// ==== src/flit_pkg.sv ====
/*
 * Flit, link and route table formats
 * Every flit carries a destination, only the head flit's one is routed
 * The credit of a link travels back as a separate single bit
 */
`default_nettype none

package flit_pkg;

    import noc_cfg_pkg::*;

    // One flit as stored in the input buffers and driven on the links
    typedef struct packed {
        flit_data_t data;
        dest_t      dest;
        logic       is_tail;
    } flit_t;

    // Forward direction of one link
    typedef struct packed {
        logic  send;
        flit_t flit;
    } link_t;

    // Entry d holds the output port for destination d
    typedef port_idx_t [NUM_ENDPOINTS-1:0] route_table_t;

endpackage

`default_nettype wire

// ==== src/noc_cfg_pkg.sv ====
/*
 * Router sizes and the plain vector types derived from them
 * Port indices and credit counts scale with NUM_PORTS and BUFFER_DEPTH
 * BUFFER_DEPTH must be a power of two for the buffer pointers to wrap
 */
`default_nettype none

package noc_cfg_pkg;

    // Router geometry
    localparam int NUM_PORTS       = 5;
    localparam int NUM_ENDPOINTS   = 8;
    localparam int BUFFER_DEPTH    = 4;
    localparam int FLIT_DATA_WIDTH = 32;
    localparam int DEST_WIDTH      = 3;

    // Derived widths
    localparam int PORT_IDX_WIDTH = $clog2(NUM_PORTS);
    localparam int BUF_PTR_WIDTH  = $clog2(BUFFER_DEPTH);
    localparam int CREDIT_WIDTH   = $clog2(BUFFER_DEPTH + 1);

    typedef logic [PORT_IDX_WIDTH-1:0]  port_idx_t;
    typedef logic [NUM_PORTS-1:0]       port_mask_t;
    typedef logic [DEST_WIDTH-1:0]      dest_t;
    typedef logic [BUF_PTR_WIDTH-1:0]   buf_ptr_t;

    // Holds the full BUFFER_DEPTH value, not just depth - 1
    typedef logic [CREDIT_WIDTH-1:0]    credit_cnt_t;

    typedef logic [FLIT_DATA_WIDTH-1:0] flit_data_t;

endpackage

`default_nettype wire
